// File: Makefile
# Verilator build and run of the vector core testbench
# The run target fails when the simulation exits with an error

VERILATOR ?= verilator
TOP ?= vector_core_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
verilog/vector_core_pkg.sv
verilog/instruction_decode.sv
verilog/register_sram_2r1w.sv
verilog/operand_fetch_stage.sv
verilog/vector_alu_stage.sv
verilog/vector_core_top.sv
verification/tb_clock_gen.sv
verification/vector_core_properties.sv
verification/vector_core_tb.sv

// File: verification/tb_clock_gen.sv
// Free-running testbench clock, reset held high from time zero
// Reset drops on a falling edge after reset_cycles full periods
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int half_period = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        #(2 * half_period * reset_cycles);
        reset = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

// File: verification/vector_core_properties.sv
// Checks on the result port of vector_core_top, attached by bind
// Sampled on the rising clock edge; a result is seen one edge after it is registered
`timescale 1ns/10ps

module vector_core_properties #(
    parameter int num_lanes = 4
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 instruction_valid,
    input logic                 result_valid,
    input logic                 result_vector,
    input logic [num_lanes-1:0] result_mask
);

    // No result leaves the core while reset is held
    result_low_in_reset: assert property (@(posedge clk) reset |-> !result_valid)
        else $error("result_valid is high during reset");

    scalar_mask_is_one: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_vector |-> result_mask == num_lanes'(1))
        else $error("scalar result with a mask other than lane 0");

    // Registered two edges after the sample, so seen here three edges later
    result_has_instruction: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(instruction_valid, 3))
        else $error("result without an instruction sampled two cycles earlier");

endmodule

// File: verification/vector_core_tb.sv
// Directed tests against a per-thread register model; inputs change on the falling edge
// Same-thread instructions are kept at least three cycles apart, as the core has no interlocks
`timescale 1ns/10ps

module vector_core_tb;
    import vector_core_pkg::*;

    localparam int num_lanes = 4;
    localparam int num_threads = 4;
    localparam int thread_width = $clog2(num_threads);
    localparam int check_width = num_lanes * word_width;
    localparam int reset_timeout = 100;
    localparam int drain_timeout = 50;
    localparam logic [31:0] random_seed = 32'h592e0385;

    logic                    clk;
    logic                    reset;
    logic                    instruction_valid;
    logic [instr_width-1:0]  instruction;
    logic [thread_width-1:0] thread_idx;
    logic                    flush_en;
    logic [thread_width-1:0] flush_thread;
    logic                    result_valid;
    logic [thread_width-1:0] result_thread;
    register_idx_t           result_reg;
    logic                    result_vector;
    logic [check_width-1:0]  result_value;
    logic [num_lanes-1:0]    result_mask;

    // Register contents as the core should hold them
    scalar_t scalar_model [num_threads][num_registers];
    scalar_t vector_model [num_threads][num_registers][num_lanes];

    // Instructions in flight that must produce a result
    int          pending_thread[$];
    logic [31:0] pending_instr[$];
    int          pending_cycle[$];

    int cycle_count = 0;

    tb_clock_gen #(
        .half_period(20),
        .reset_cycles(16)
    ) clock_gen_i (
        .clk(clk),
        .reset(reset)
    );

    vector_core_top #(
        .num_lanes(num_lanes),
        .num_threads(num_threads)
    ) vector_core_top_i (
        .*
    );

    bind vector_core_top vector_core_properties #(
        .num_lanes(num_lanes)
    ) properties_i (
        .clk(clk),
        .reset(reset),
        .instruction_valid(instruction_valid),
        .result_valid(result_valid),
        .result_vector(result_vector),
        .result_mask(result_mask)
    );

    always @(posedge clk)
        cycle_count++;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [check_width-1:0] got,
                               input logic [check_width-1:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, name, got, expected));
    endtask

    function automatic scalar_t reference_op(alu_op_t op, scalar_t a, scalar_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_shl:  return a << b[4:0];
            op_shr:  return a >> b[4:0];
            default: return b;
        endcase
    endfunction

    function automatic logic [31:0] encode(alu_op_t op, instr_form_t form, int dest,
                                           int src1, int src2, int imm);
        return {op, form, 5'(dest), 5'(src1), 5'(src2), 10'(imm)};
    endfunction

    function automatic int rand_reg();
        return int'($urandom_range(31, 0));
    endfunction

    // Predicts the result from the model at the time it leaves the core
    task automatic check_result();
        int                     t;
        logic [31:0]            instr;
        int                     sampled;
        alu_op_t                op;
        logic [2:0]             form_bits;
        instr_form_t            form;
        register_idx_t          dest;
        register_idx_t          src1;
        register_idx_t          src2;
        scalar_t                imm;
        bit                     vec;
        scalar_t                a;
        scalar_t                b;
        logic [check_width-1:0] exp_value;
        logic [num_lanes-1:0]   exp_mask;

        if (pending_instr.size() == 0)
            stop_with_failure("result_valid was high with no instruction in flight");
        else
        begin
            t = pending_thread.pop_front();
            instr = pending_instr.pop_front();
            sampled = pending_cycle.pop_front();
            op = alu_op_t'(instr[31:28]);
            form_bits = instr[27:25];
            // Unused form codes act as scalar op scalar
            if (form_bits > 3'd5)
                form_bits = 3'd0;
            form = instr_form_t'(form_bits);
            dest = instr[24:20];
            src1 = instr[19:15];
            src2 = instr[14:10];
            imm = {{22{instr[9]}}, instr[9:0]};
            vec = form inside {form_vv, form_vs, form_vi, form_vim};

            exp_value = '0;
            for (int lane = 0; lane < num_lanes; lane++)
            begin
                a = vec ? vector_model[t][src1][lane] : scalar_model[t][src1];
                case (form)
                    form_vv:                    b = vector_model[t][src2][lane];
                    form_si, form_vi, form_vim: b = imm;
                    default:                    b = scalar_model[t][src2];
                endcase
                if (vec || lane == 0)
                    exp_value[lane*word_width +: word_width] = reference_op(op, a, b);
            end
            if (form == form_vim)
                exp_mask = scalar_model[t][src2][num_lanes-1:0];
            else if (vec)
                exp_mask = '1;
            else
                exp_mask = num_lanes'(1);

            check_value("result_thread", check_width'(result_thread), check_width'(t));
            check_value("result_reg", check_width'(result_reg), check_width'(dest));
            check_value("result_vector", check_width'(result_vector), check_width'(vec));
            check_value("result_value", result_value, exp_value);
            check_value("result_mask", check_width'(result_mask), check_width'(exp_mask));
            check_value("result latency", check_width'(cycle_count - sampled),
                        check_width'(2));

            // Write-back, lanes outside the mask keep their values
            if (vec)
            begin
                for (int lane = 0; lane < num_lanes; lane++)
                begin
                    if (exp_mask[lane])
                        vector_model[t][dest][lane] = exp_value[lane*word_width +: word_width];
                end
            end
            else
                scalar_model[t][dest] = exp_value[word_width-1:0];
        end
    endtask

    always @(negedge clk)
    begin
        if (result_valid)
            check_result();
    end

    task automatic issue(input int thread, input logic [31:0] instr,
                         input bit produces_result = 1'b1, input bit flush = 1'b0,
                         input int flushed_thread = 0);
        @(negedge clk);
        instruction_valid = 1'b1;
        instruction = instr;
        thread_idx = thread_width'(thread);
        flush_en = flush;
        flush_thread = thread_width'(flushed_thread);
        if (produces_result)
        begin
            pending_thread.push_back(thread);
            pending_instr.push_back(instr);
            pending_cycle.push_back(cycle_count + 1);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            instruction_valid = 1'b0;
            flush_en = 1'b0;
        end
    endtask

    // Three cycles per instruction, enough for a dependent one to follow
    task automatic issue_spaced(input int thread, input logic [31:0] instr);
        issue(thread, instr);
        idle(2);
    endtask

    task automatic wait_drain();
        int waited;

        waited = 0;
        while (pending_instr.size() != 0 && waited < drain_timeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending_instr.size() != 0)
            stop_with_failure("timed out waiting for result_valid");
    endtask

    task automatic wait_reset_release();
        int waited;

        waited = 0;
        @(posedge clk);
        while (reset && waited < reset_timeout)
        begin
            @(posedge clk);
            waited++;
        end
        if (reset)
            stop_with_failure("reset was never released");
    endtask

    // Every register of every thread from a sign-extended immediate
    task automatic test_init_registers();
        for (int r = 0; r < num_registers; r++)
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_move, form_si, r, 0, 0, $urandom));
        for (int r = 0; r < num_registers; r++)
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_move, form_vi, r, 0, 0, $urandom));
        idle(1);
        wait_drain();
    endtask

    task automatic test_all_operations();
        alu_op_t op;

        // Give the lanes different contents first
        for (int n = 0; n < 16; n++)
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_move, form_vim, rand_reg(), 0, rand_reg(), $urandom));
        idle(1);
        wait_drain();

        op = op.first();
        do
        begin
            for (int t = 0; t < num_threads; t++)
                for (int rep = 0; rep < 2; rep++)
                begin
                    issue_spaced(t, encode(op, form_ss, rand_reg(), rand_reg(), rand_reg(), 0));
                    issue_spaced(t, encode(op, form_vv, rand_reg(), rand_reg(), rand_reg(), 0));
                end
            op = op.next();
        end
        while (op != op.first());

        // Form code 6 is unused and behaves as form_ss
        for (int t = 0; t < num_threads; t++)
            issue_spaced(t, encode(op_add, instr_form_t'(3'd6), rand_reg(), rand_reg(),
                                   rand_reg(), 0));
        wait_drain();
    endtask

    task automatic test_broadcast_and_mask();
        int vd;

        for (int t = 0; t < num_threads; t++)
            for (int rep = 0; rep < 4; rep++)
            begin
                vd = int'($urandom_range(29, 0));
                issue_spaced(t, encode(op_add, form_vs, vd, rand_reg(), rand_reg(), 0));
                issue_spaced(t, encode(op_xor, form_vi, vd, vd, 0, $urandom));
                // Lane enables in the low bits of s31
                issue_spaced(t, encode(op_move, form_si, 31, 0, 0, $urandom));
                issue_spaced(t, encode(op_move, form_vim, vd, 0, 31, $urandom));
                issue_spaced(t, encode(op_move, form_vv, 30, 0, vd, 0));
            end
        wait_drain();
    endtask

    // Same register numbers in every thread, one instruction per cycle
    task automatic test_thread_interleave();
        for (int round = 0; round < 3; round++)
        begin
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_move, form_si, 3, 0, 0, $urandom));
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_move, form_vi, 3, 0, 0, $urandom));
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_sub, form_ss, 4, 3, rand_reg(), 0));
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_add, form_vs, 4, 3, 3, 0));
            for (int t = 0; t < num_threads; t++)
                issue(t, encode(op_move, form_vv, 5, 0, 4, 0));
        end
        idle(1);
        wait_drain();
    endtask

    task automatic test_flush();
        // Thread 1 is flushed while thread 2 enters at the flush edge
        issue(1, encode(op_move, form_si, 9, 0, 0, $urandom), 1'b0);
        issue(2, encode(op_move, form_si, 9, 0, 0, $urandom), 1'b1, 1'b1, 1);
        idle(3);
        wait_drain();

        // Thread 3 sampled at its own flush edge still completes
        issue(3, encode(op_move, form_vi, 10, 0, 0, $urandom), 1'b0);
        issue(3, encode(op_move, form_si, 11, 0, 0, $urandom), 1'b1, 1'b1, 3);
        idle(3);
        wait_drain();

        // A flush naming thread 2 leaves the held thread 0 alone
        issue(0, encode(op_move, form_vi, 10, 0, 0, $urandom));
        issue(1, encode(op_move, form_si, 14, 0, 0, $urandom), 1'b1, 1'b1, 2);
        idle(3);
        wait_drain();

        // Flushed destinations still hold their old values
        issue_spaced(1, encode(op_move, form_ss, 12, 0, 9, 0));
        issue_spaced(3, encode(op_move, form_vv, 13, 0, 10, 0));
        issue_spaced(2, encode(op_move, form_ss, 12, 0, 9, 0));
        wait_drain();
    endtask

    initial
    begin
        instruction_valid = 1'b0;
        instruction = '0;
        thread_idx = '0;
        flush_en = 1'b0;
        flush_thread = '0;
        void'($urandom(random_seed));

        wait_reset_release();
        test_init_registers();
        test_all_operations();
        test_broadcast_and_mask();
        test_thread_interleave();
        test_flush();
        idle(4);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: verilog/instruction_decode.sv
// Registers the instruction and splits it into selects and sources
// Unused form encodings behave as form_ss; num_threads must be a power of two, at least 2
`timescale 1ns/10ps

module instruction_decode #(
    parameter int num_threads = 4
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   instruction_valid,
    input  logic [vector_core_pkg::instr_width-1:0] instruction,
    input  logic [$clog2(num_threads)-1:0]         thread_idx,
    output logic                                   dc_valid,
    output logic [$clog2(num_threads)-1:0]         dc_thread,
    output vector_core_pkg::alu_op_t               dc_op,
    output logic                                   dc_vector_dest,
    output vector_core_pkg::register_idx_t         dc_dest,
    output vector_core_pkg::register_idx_t         dc_src1,
    output vector_core_pkg::register_idx_t         dc_src2,
    output vector_core_pkg::scalar_t               dc_immediate,
    output vector_core_pkg::op1_src_t              dc_op1_src,
    output vector_core_pkg::op2_src_t              dc_op2_src,
    output vector_core_pkg::mask_src_t             dc_mask_src
);
    import vector_core_pkg::*;

    instr_form_t          form;
    logic                 vector_dest;
    op1_src_t             op1_src;
    op2_src_t             op2_src;
    mask_src_t            mask_src;
    logic [imm_width-1:0] imm_field;

    assign form = instr_form_t'(instruction[form_lsb +: $bits(instr_form_t)]);
    assign imm_field = instruction[imm_width-1:0];

    always_comb
    begin
        // Start from scalar op scalar
        vector_dest = 1'b0;
        op1_src = op1_scalar;
        op2_src = op2_scalar;
        mask_src = mask_all_ones;
        case (form)
            form_si:
                op2_src = op2_immediate;
            form_vv:
            begin
                vector_dest = 1'b1;
                op1_src = op1_vector;
                op2_src = op2_vector;
            end
            form_vs:
            begin
                vector_dest = 1'b1;
                op1_src = op1_vector;
            end
            form_vi:
            begin
                vector_dest = 1'b1;
                op1_src = op1_vector;
                op2_src = op2_immediate;
            end
            form_vim:
            begin
                vector_dest = 1'b1;
                op1_src = op1_vector;
                op2_src = op2_immediate;
                mask_src = mask_scalar2;    // lanes enabled by scalar src2
            end
            default:
                ;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            dc_valid <= 1'b0;
        else
            dc_valid <= instruction_valid;
    end

    always_ff @(posedge clk)
    begin
        dc_thread <= thread_idx;
        dc_op <= alu_op_t'(instruction[op_lsb +: $bits(alu_op_t)]);
        dc_vector_dest <= vector_dest;
        dc_dest <= instruction[dest_lsb +: $bits(register_idx_t)];
        dc_src1 <= instruction[src1_lsb +: $bits(register_idx_t)];
        dc_src2 <= instruction[src2_lsb +: $bits(register_idx_t)];
        dc_immediate <= {{(word_width - imm_width){imm_field[imm_width-1]}}, imm_field};
        dc_op1_src <= op1_src;
        dc_op2_src <= op2_src;
        dc_mask_src <= mask_src;
    end

endmodule

// File: verilog/operand_fetch_stage.sv
// Scalar and vector register files, addressed by {thread, register}
// Operands come straight from the array outputs after the read edge
`timescale 1ns/10ps

module operand_fetch_stage #(
    parameter int num_lanes = 4,
    parameter int num_threads = 4
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           dc_valid,
    input  logic [$clog2(num_threads)-1:0]                 dc_thread,
    input  vector_core_pkg::alu_op_t                       dc_op,
    input  logic                                           dc_vector_dest,
    input  vector_core_pkg::register_idx_t                 dc_dest,
    input  vector_core_pkg::register_idx_t                 dc_src1,
    input  vector_core_pkg::register_idx_t                 dc_src2,
    input  vector_core_pkg::scalar_t                       dc_immediate,
    input  vector_core_pkg::op1_src_t                      dc_op1_src,
    input  vector_core_pkg::op2_src_t                      dc_op2_src,
    input  vector_core_pkg::mask_src_t                     dc_mask_src,
    input  logic                                           flush_en,
    input  logic [$clog2(num_threads)-1:0]                 flush_thread,
    output logic                                           of_valid,
    output logic [$clog2(num_threads)-1:0]                 of_thread,
    output vector_core_pkg::alu_op_t                       of_op,
    output logic                                           of_vector_dest,
    output vector_core_pkg::register_idx_t                 of_dest,
    output logic [num_lanes*vector_core_pkg::word_width-1:0] of_operand1,
    output logic [num_lanes*vector_core_pkg::word_width-1:0] of_operand2,
    output logic [num_lanes-1:0]                           of_mask,
    input  logic                                           wb_en,
    input  logic [$clog2(num_threads)-1:0]                 wb_thread,
    input  vector_core_pkg::register_idx_t                 wb_reg,
    input  logic                                           wb_vector,
    input  logic [num_lanes*vector_core_pkg::word_width-1:0] wb_value,
    input  logic [num_lanes-1:0]                           wb_mask
);
    import vector_core_pkg::*;

    localparam int file_depth = num_registers * num_threads;

    scalar_t                         scalar_val1;
    scalar_t                         scalar_val2;
    logic [num_lanes*word_width-1:0] vector_val1;
    logic [num_lanes*word_width-1:0] vector_val2;
    op1_src_t                        op1_src;
    op2_src_t                        op2_src;
    mask_src_t                       mask_src;
    scalar_t                         immediate;

    register_sram_2r1w #(
        .depth(file_depth)
    ) scalar_registers (
        .clk(clk),
        .read1_en(dc_valid && dc_op1_src == op1_scalar),
        .read1_addr({dc_thread, dc_src1}),
        .read1_data(scalar_val1),
        .read2_en(dc_valid && (dc_op2_src == op2_scalar || dc_mask_src == mask_scalar2)),
        .read2_addr({dc_thread, dc_src2}),
        .read2_data(scalar_val2),
        .write_en(wb_en && !wb_vector),
        .write_addr({wb_thread, wb_reg}),
        .write_data(wb_value[word_width-1:0])
    );

    // One array per lane, written only where the mask bit is set
    for (genvar lane = 0; lane < num_lanes; lane++)
    begin : vector_lane_gen
        register_sram_2r1w #(
            .depth(file_depth)
        ) vector_registers (
            .clk(clk),
            .read1_en(dc_valid && dc_op1_src == op1_vector),
            .read1_addr({dc_thread, dc_src1}),
            .read1_data(vector_val1[lane*word_width +: word_width]),
            .read2_en(dc_valid && dc_op2_src == op2_vector),
            .read2_addr({dc_thread, dc_src2}),
            .read2_data(vector_val2[lane*word_width +: word_width]),
            .write_en(wb_en && wb_vector && wb_mask[lane]),
            .write_addr({wb_thread, wb_reg}),
            .write_data(wb_value[lane*word_width +: word_width])
        );
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            of_valid <= 1'b0;
        else
            of_valid <= dc_valid && !(flush_en && flush_thread == dc_thread);
    end

    always_ff @(posedge clk)
    begin
        of_thread <= dc_thread;
        of_op <= dc_op;
        of_vector_dest <= dc_vector_dest;
        of_dest <= dc_dest;
        op1_src <= dc_op1_src;
        op2_src <= dc_op2_src;
        mask_src <= dc_mask_src;
        immediate <= dc_immediate;
    end

    always_comb
    begin
        case (op1_src)
            op1_vector: of_operand1 = vector_val1;
            default:    of_operand1 = {num_lanes{scalar_val1}};
        endcase

        case (op2_src)
            op2_vector:    of_operand2 = vector_val2;
            op2_immediate: of_operand2 = {num_lanes{immediate}};
            default:       of_operand2 = {num_lanes{scalar_val2}};
        endcase

        case (mask_src)
            mask_scalar2: of_mask = scalar_val2[num_lanes-1:0];
            default:      of_mask = {num_lanes{1'b1}};
        endcase
    end

endmodule

// File: verilog/register_sram_2r1w.sv
// Registered reads; a read of the address written at the same edge is undefined
// Contents are not reset
`timescale 1ns/10ps

module register_sram_2r1w #(
    parameter int depth = 128
) (
    input  logic                           clk,
    input  logic                           read1_en,
    input  logic [$clog2(depth)-1:0]       read1_addr,
    output vector_core_pkg::scalar_t       read1_data,
    input  logic                           read2_en,
    input  logic [$clog2(depth)-1:0]       read2_addr,
    output vector_core_pkg::scalar_t       read2_data,
    input  logic                           write_en,
    input  logic [$clog2(depth)-1:0]       write_addr,
    input  vector_core_pkg::scalar_t       write_data
);
    import vector_core_pkg::*;

    scalar_t data [depth];

    always_ff @(posedge clk)
    begin
        if (write_en)
            data[write_addr] <= write_data;
        // Read data holds its last value when not enabled
        if (read1_en)
            read1_data <= data[read1_addr];
        if (read2_en)
            read2_data <= data[read2_addr];
    end

endmodule

// File: verilog/vector_alu_stage.sv
// One ALU per lane with a registered result that also feeds register write-back
// Scalar results keep lane 0 only, with mask bit 0 set
`timescale 1ns/10ps

module vector_alu_stage #(
    parameter int num_lanes = 4,
    parameter int num_threads = 4
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             of_valid,
    input  logic [$clog2(num_threads)-1:0]                   of_thread,
    input  vector_core_pkg::alu_op_t                         of_op,
    input  logic                                             of_vector_dest,
    input  vector_core_pkg::register_idx_t                   of_dest,
    input  logic [num_lanes*vector_core_pkg::word_width-1:0] of_operand1,
    input  logic [num_lanes*vector_core_pkg::word_width-1:0] of_operand2,
    input  logic [num_lanes-1:0]                             of_mask,
    output logic                                             result_valid,
    output logic [$clog2(num_threads)-1:0]                   result_thread,
    output vector_core_pkg::register_idx_t                   result_reg,
    output logic                                             result_vector,
    output logic [num_lanes*vector_core_pkg::word_width-1:0] result_value,
    output logic [num_lanes-1:0]                             result_mask
);
    import vector_core_pkg::*;

    localparam int vector_width = num_lanes * word_width;

    logic [vector_width-1:0] lane_result;

    function automatic scalar_t lane_op(alu_op_t op, scalar_t a, scalar_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_shl:  return a << b[4:0];
            op_shr:  return a >> b[4:0];
            // op_move and unused opcodes pass operand 2
            default: return b;
        endcase
    endfunction

    always_comb
    begin
        for (int lane = 0; lane < num_lanes; lane++)
        begin
            lane_result[lane*word_width +: word_width] = lane_op(of_op,
                of_operand1[lane*word_width +: word_width],
                of_operand2[lane*word_width +: word_width]);
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= of_valid;
    end

    always_ff @(posedge clk)
    begin
        result_thread <= of_thread;
        result_reg <= of_dest;
        result_vector <= of_vector_dest;
        if (of_vector_dest)
        begin
            result_value <= lane_result;
            result_mask <= of_mask;
        end
        else
        begin
            // Lane 0 only, upper lanes cleared
            result_value <= vector_width'(lane_result[word_width-1:0]);
            result_mask <= num_lanes'(1);
        end
    end

endmodule

// File: verilog/vector_core_pkg.sv
// Instruction layout is op[31:28] form[27:25] dest[24:20] src1[19:15] src2[14:10] imm[9:0]
// Immediate is sign-extended to a full lane; shifts use the low 5 bits of operand 2
package vector_core_pkg;

    parameter int word_width = 32;
    parameter int num_registers = 32;
    parameter int instr_width = 32;
    parameter int imm_width = 10;

    // Field positions in the instruction word
    parameter int op_lsb = 28;
    parameter int form_lsb = 25;
    parameter int dest_lsb = 20;
    parameter int src1_lsb = 15;
    parameter int src2_lsb = 10;

    typedef logic [word_width-1:0] scalar_t;
    typedef logic [4:0] register_idx_t;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_shl  = 4'd5,
        op_shr  = 4'd6,
        op_move = 4'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        form_ss  = 3'd0,
        form_si  = 3'd1,
        form_vv  = 3'd2,
        form_vs  = 3'd3,
        form_vi  = 3'd4,
        form_vim = 3'd5
    } instr_form_t;

    typedef enum logic {
        op1_scalar,
        op1_vector
    } op1_src_t;

    typedef enum logic [1:0] {
        op2_scalar,
        op2_vector,
        op2_immediate
    } op2_src_t;

    typedef enum logic {
        mask_all_ones,
        mask_scalar2
    } mask_src_t;

endpackage

// File: verilog/vector_core_top.sv
// Decode, operand fetch and ALU with a fixed 2-cycle latency and no interlocks
// num_lanes at most 32; num_threads a power of two, at least 2
`timescale 1ns/10ps

module vector_core_top #(
    parameter int num_lanes = 4,
    parameter int num_threads = 4
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             instruction_valid,
    input  logic [vector_core_pkg::instr_width-1:0]          instruction,
    input  logic [$clog2(num_threads)-1:0]                   thread_idx,
    input  logic                                             flush_en,
    input  logic [$clog2(num_threads)-1:0]                   flush_thread,
    output logic                                             result_valid,
    output logic [$clog2(num_threads)-1:0]                   result_thread,
    output vector_core_pkg::register_idx_t                   result_reg,
    output logic                                             result_vector,
    output logic [num_lanes*vector_core_pkg::word_width-1:0] result_value,
    output logic [num_lanes-1:0]                             result_mask
);
    import vector_core_pkg::*;

    localparam int thread_width = $clog2(num_threads);

    // Decode to fetch
    logic                    dc_valid;
    logic [thread_width-1:0] dc_thread;
    alu_op_t                 dc_op;
    logic                    dc_vector_dest;
    register_idx_t           dc_dest;
    register_idx_t           dc_src1;
    register_idx_t           dc_src2;
    scalar_t                 dc_immediate;
    op1_src_t                dc_op1_src;
    op2_src_t                dc_op2_src;
    mask_src_t               dc_mask_src;

    // Fetch to ALU
    logic                            of_valid;
    logic [thread_width-1:0]         of_thread;
    alu_op_t                         of_op;
    logic                            of_vector_dest;
    register_idx_t                   of_dest;
    logic [num_lanes*word_width-1:0] of_operand1;
    logic [num_lanes*word_width-1:0] of_operand2;
    logic [num_lanes-1:0]            of_mask;

    instruction_decode #(
        .num_threads(num_threads)
    ) instruction_decode_i (
        .*
    );

    // The result outputs double as the register file write port
    operand_fetch_stage #(
        .num_lanes(num_lanes),
        .num_threads(num_threads)
    ) operand_fetch_stage_i (
        .wb_en(result_valid),
        .wb_thread(result_thread),
        .wb_reg(result_reg),
        .wb_vector(result_vector),
        .wb_value(result_value),
        .wb_mask(result_mask),
        .*
    );

    vector_alu_stage #(
        .num_lanes(num_lanes),
        .num_threads(num_threads)
    ) vector_alu_stage_i (
        .*
    );

endmodule
